// ==== verilog/bpu_pkg.sv ====
`default_nettype none

package bpu_pkg;

    // basic widths
    parameter int XLEN    = 32;
    parameter int GHIST_W = 16;

    typedef logic [XLEN-1:0]    addr_t;
    typedef logic [XLEN-1:0]    inst_t;
    typedef logic [GHIST_W-1:0] ghist_t;

    // 2-bit saturating counter, msb is the taken guess
    typedef logic [1:0] ctr_t;

    parameter ctr_t CTR_STRONG_NT = 2'b00;
    parameter ctr_t CTR_WEAK_NT   = 2'b01;
    parameter ctr_t CTR_WEAK_T    = 2'b10;
    parameter ctr_t CTR_STRONG_T  = 2'b11;

    // component that supplied the direction
    typedef enum logic [1:0] {
        PROV_BIMODAL = 2'd0,
        PROV_T0      = 2'd1,
        PROV_T1      = 2'd2
    } provider_e;

    // tag widths
    parameter int TAGE_TAG_W = 10;
    parameter int BTB_TAG_W  = 22;

    // rv32 opcodes of interest
    parameter logic [6:0] OPC_BRANCH = 7'b1100011;
    parameter logic [6:0] OPC_JAL    = 7'b1101111;
    parameter logic [6:0] OPC_JALR   = 7'b1100111;

    // link registers, used for return detection
    parameter logic [4:0] REG_RA = 5'd1;
    parameter logic [4:0] REG_T0 = 5'd5;

endpackage

`default_nettype wire

// ==== verilog/tagged_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module tagged_table #(
    parameter int  ENTRIES   = 256,
    parameter int  TAG_W     = 10,
    parameter type payload_t = logic [1:0]
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    // lookup port
    input  wire logic [$clog2(ENTRIES)-1:0] rd_index_i,
    input  wire logic [TAG_W-1:0]           rd_tag_i,
    output logic                            hit_o,
    output payload_t                        rd_data_o,
    // write port
    input  wire logic                       wr_en_i,
    input  wire logic [$clog2(ENTRIES)-1:0] wr_index_i,
    input  wire logic [TAG_W-1:0]           wr_tag_i,
    input  wire payload_t                   wr_data_i,
    output logic                            match_wr_o
);

    localparam int IDX_W = $clog2(ENTRIES);

    logic [ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]   tag_mem  [ENTRIES];
    payload_t           data_mem [ENTRIES];

    // async read, a same-cycle write shows up next cycle
    assign hit_o     = valid_q[rd_index_i] && (tag_mem[rd_index_i] == rd_tag_i);
    assign rd_data_o = data_mem[rd_index_i];

    // does the write slot already hold this tag
    assign match_wr_o = valid_q[wr_index_i] && (tag_mem[wr_index_i] == wr_tag_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[wr_index_i]  <= wr_tag_i;
            data_mem[wr_index_i] <= wr_data_i;
        end
    end

    // index width must cover the table
    initial begin
        if ((1 << IDX_W) != ENTRIES) begin
            $error("tagged_table: ENTRIES must be a power of two");
        end
    end

endmodule

`default_nettype wire

// ==== verilog/inst_predecode.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_predecode import bpu_pkg::*; (
    input  wire addr_t if_pc_i,
    input  wire inst_t if_inst_i,
    output logic       is_branch_o,
    output logic       is_jal_o,
    output logic       is_jalr_o,
    output logic       is_ret_o,
    output addr_t      branch_target_o,
    output addr_t      jal_target_o
);

    logic [6:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    addr_t      b_imm;
    addr_t      j_imm;

    assign opcode = if_inst_i[6:0];
    assign rd     = if_inst_i[11:7];
    assign rs1    = if_inst_i[19:15];

    assign is_branch_o = (opcode == OPC_BRANCH);
    assign is_jal_o    = (opcode == OPC_JAL);
    assign is_jalr_o   = (opcode == OPC_JALR);

    // jalr x0, 0(ra) or jalr x0, 0(t0)
    assign is_ret_o = is_jalr_o && (rd == 5'd0)
                   && ((rs1 == REG_RA) || (rs1 == REG_T0))
                   && (if_inst_i[31:20] == 12'd0);

    // B-type immediate, bit 0 always zero
    assign b_imm = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25],
                    if_inst_i[11:8], 1'b0};

    // J-type immediate
    assign j_imm = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20],
                    if_inst_i[30:21], 1'b0};

    assign branch_target_o = if_pc_i + b_imm;
    assign jal_target_o    = if_pc_i + j_imm;

endmodule

`default_nettype wire

// ==== verilog/direction_predictor.sv ====
`timescale 1ns/100ps
`default_nettype none

module direction_predictor import bpu_pkg::*; #(
    parameter int BIMODAL_ENTRIES = 512,
    parameter int TAGE_ENTRIES    = 256
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire addr_t     if_pc_i,
    output logic           pred_taken_o,
    output provider_e      provider_o,
    input  wire logic      ex_valid_i,
    input  wire logic      ex_taken_i,
    input  wire logic      ex_correct_i,
    input  wire addr_t     ex_pc_i,
    input  wire ghist_t    ex_history_i,
    input  wire provider_e ex_provider_i,
    output ghist_t         history_o
);

    localparam int BM_IDX_W   = $clog2(BIMODAL_ENTRIES);
    localparam int TAGE_IDX_W = $clog2(TAGE_ENTRIES);

    typedef logic [TAGE_IDX_W-1:0] tidx_t;
    typedef logic [TAGE_TAG_W-1:0] ttag_t;

    // short history for T0, long end of the history for T1
    function automatic tidx_t t0_index(addr_t pc, ghist_t h);
        return pc[TAGE_IDX_W-1:0] ^ h[TAGE_IDX_W-1:0];
    endfunction

    function automatic ttag_t t0_tag(addr_t pc, ghist_t h);
        return pc[TAGE_IDX_W +: TAGE_TAG_W] ^ h[GHIST_W-1 -: TAGE_TAG_W];
    endfunction

    function automatic tidx_t t1_index(addr_t pc, ghist_t h);
        return pc[TAGE_IDX_W-1:0] ^ h[GHIST_W-1 -: TAGE_IDX_W];
    endfunction

    function automatic ttag_t t1_tag(addr_t pc, ghist_t h);
        return pc[TAGE_IDX_W +: TAGE_TAG_W] ^ TAGE_TAG_W'(h[TAGE_IDX_W-1:0]);
    endfunction

    function automatic ctr_t ctr_step(ctr_t c, logic taken);
        if (taken) begin
            return (c == CTR_STRONG_T) ? c : c + 2'd1;
        end
        return (c == CTR_STRONG_NT) ? c : c - 2'd1;
    endfunction

    ctr_t   bimodal_q [BIMODAL_ENTRIES];
    ghist_t ghist_q;

    logic [BM_IDX_W-1:0] bm_idx;
    logic [BM_IDX_W-1:0] bm_idx_u;
    logic                t0_hit, t1_hit;
    ctr_t                t0_ctr, t1_ctr;
    logic                t0_match_wr, t1_match_wr;
    logic                t0_wr_en, t1_wr_en;
    ctr_t                t0_wr_data, t1_wr_data;

    assign bm_idx   = if_pc_i[BM_IDX_W:1];
    assign bm_idx_u = ex_pc_i[BM_IDX_W:1];

    tagged_table #(
        .ENTRIES (TAGE_ENTRIES), .TAG_W (TAGE_TAG_W), .payload_t (ctr_t)
    ) u_t0 (
        .clk        (clk),
        .rst        (rst),
        .rd_index_i (t0_index(if_pc_i, ghist_q)),
        .rd_tag_i   (t0_tag(if_pc_i, ghist_q)),
        .hit_o      (t0_hit),
        .rd_data_o  (t0_ctr),
        .wr_en_i    (t0_wr_en),
        .wr_index_i (t0_index(ex_pc_i, ex_history_i)),
        .wr_tag_i   (t0_tag(ex_pc_i, ex_history_i)),
        .wr_data_i  (t0_wr_data),
        .match_wr_o (t0_match_wr)
    );

    tagged_table #(
        .ENTRIES (TAGE_ENTRIES), .TAG_W (TAGE_TAG_W), .payload_t (ctr_t)
    ) u_t1 (
        .clk        (clk),
        .rst        (rst),
        .rd_index_i (t1_index(if_pc_i, ghist_q)),
        .rd_tag_i   (t1_tag(if_pc_i, ghist_q)),
        .hit_o      (t1_hit),
        .rd_data_o  (t1_ctr),
        .wr_en_i    (t1_wr_en),
        .wr_index_i (t1_index(ex_pc_i, ex_history_i)),
        .wr_tag_i   (t1_tag(ex_pc_i, ex_history_i)),
        .wr_data_i  (t1_wr_data),
        .match_wr_o (t1_match_wr)
    );

    // longest history wins
    always_comb begin
        if (t1_hit) begin
            provider_o   = PROV_T1;
            pred_taken_o = t1_ctr[1];
        end else if (t0_hit) begin
            provider_o   = PROV_T0;
            pred_taken_o = t0_ctr[1];
        end else begin
            provider_o   = PROV_BIMODAL;
            pred_taken_o = bimodal_q[bm_idx][1];
        end
    end

    // tagged training. a correct provider already points at the outcome,
    // so one step toward it lands on strong, same as the mispredict reset
    always_comb begin
        t0_wr_en   = 1'b0;
        t1_wr_en   = 1'b0;
        t0_wr_data = ex_taken_i ? CTR_STRONG_T : CTR_STRONG_NT;
        t1_wr_data = ex_taken_i ? CTR_STRONG_T : CTR_STRONG_NT;
        if (ex_valid_i) begin
            case (ex_provider_i)
                PROV_T1: t1_wr_en = t1_match_wr;  // only if entry still ours
                PROV_T0: t0_wr_en = t0_match_wr;
                PROV_BIMODAL: begin
                    if (!ex_correct_i) begin
                        if (!t1_match_wr) begin
                            t1_wr_en   = 1'b1;
                            t1_wr_data = ex_taken_i ? CTR_WEAK_T : CTR_WEAK_NT;
                        end else begin
                            t0_wr_en   = 1'b1;
                            t0_wr_data = ex_taken_i ? CTR_WEAK_T : CTR_WEAK_NT;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist_q <= '0;
            for (int i = 0; i < BIMODAL_ENTRIES; i++) begin
                bimodal_q[i] <= CTR_WEAK_NT;
            end
        end else if (ex_valid_i) begin
            ghist_q <= {ghist_q[GHIST_W-2:0], ex_taken_i};  // newest outcome in bit 0
            bimodal_q[bm_idx_u] <= ctr_step(bimodal_q[bm_idx_u], ex_taken_i);
        end
    end

    assign history_o = ghist_q;

endmodule

`default_nettype wire

// ==== verilog/return_stack.sv ====
`timescale 1ns/100ps
`default_nettype none

module return_stack import bpu_pkg::*; #(
    parameter int RAS_DEPTH = 64
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  push_i,
    input  wire addr_t push_addr_i,
    input  wire logic  pop_i,
    output addr_t      top_o,
    output logic       valid_o
);

    localparam int IDX_W = $clog2(RAS_DEPTH);
    localparam int PTR_W = $clog2(RAS_DEPTH + 1);  // room for the full count

    addr_t            stack_mem [RAS_DEPTH];
    logic [PTR_W-1:0] sp_q;          // number of valid entries
    logic [PTR_W-1:0] sp_popped;
    logic [IDX_W-1:0] top_idx;
    logic             do_push;

    // pop first, push then lands where the old top was
    assign sp_popped = (pop_i && (sp_q != '0)) ? sp_q - 1'b1 : sp_q;
    assign do_push   = push_i && (sp_popped < RAS_DEPTH);  // drop when full

    assign top_idx = IDX_W'(sp_q - 1'b1);
    assign top_o   = stack_mem[top_idx];
    assign valid_o = (sp_q != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else if (do_push) begin
            sp_q <= sp_popped + 1'b1;
        end else begin
            sp_q <= sp_popped;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_mem[IDX_W'(sp_popped)] <= push_addr_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/target_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module target_select import bpu_pkg::*; #(
    parameter int BTB_ENTRIES = 256
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire addr_t     if_pc_i,
    input  wire logic      is_branch_i,
    input  wire logic      is_jal_i,
    input  wire logic      is_jalr_i,
    input  wire logic      is_ret_i,
    input  wire addr_t     branch_target_i,
    input  wire addr_t     jal_target_i,
    input  wire logic      pred_taken_i,
    input  wire provider_e pred_provider_i,
    input  wire addr_t     ras_top_i,
    input  wire logic      ras_valid_i,
    input  wire logic      ex_valid_i,
    input  wire logic      ex_taken_i,
    input  wire addr_t     ex_pc_i,
    input  wire addr_t     ex_target_i,
    output logic           branch_o,
    output logic           taken_o,
    output addr_t          target_o,
    output provider_e      provider_o
);

    localparam int BTB_IDX_W = $clog2(BTB_ENTRIES);

    logic  btb_hit;
    addr_t btb_target;
    addr_t pc_plus4;

    tagged_table #(
        .ENTRIES (BTB_ENTRIES), .TAG_W (BTB_TAG_W), .payload_t (addr_t)
    ) u_btb (
        .clk        (clk),
        .rst        (rst),
        .rd_index_i (if_pc_i[BTB_IDX_W+1:2]),   // word aligned index
        .rd_tag_i   (if_pc_i[XLEN-1 -: BTB_TAG_W]),
        .hit_o      (btb_hit),
        .rd_data_o  (btb_target),
        .wr_en_i    (ex_valid_i && ex_taken_i),  // learn taken targets only
        .wr_index_i (ex_pc_i[BTB_IDX_W+1:2]),
        .wr_tag_i   (ex_pc_i[XLEN-1 -: BTB_TAG_W]),
        .wr_data_i  (ex_target_i),
        .match_wr_o ()
    );

    assign pc_plus4   = if_pc_i + 32'd4;
    assign branch_o   = is_branch_i || is_jal_i || is_jalr_i;
    assign provider_o = is_branch_i ? pred_provider_i : PROV_BIMODAL;

    always_comb begin
        taken_o  = 1'b0;
        target_o = pc_plus4;
        if (is_ret_i) begin
            taken_o  = ras_valid_i;   // empty stack falls through
            target_o = ras_valid_i ? ras_top_i : pc_plus4;
        end else if (is_jal_i) begin
            taken_o  = 1'b1;
            target_o = btb_hit ? btb_target : jal_target_i;
        end else if (is_jalr_i) begin
            // no immediate fallback for indirect jumps
            taken_o  = btb_hit;
            target_o = btb_hit ? btb_target : pc_plus4;
        end else if (is_branch_i && pred_taken_i) begin
            taken_o  = 1'b1;
            target_o = btb_hit ? btb_target : branch_target_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/bpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module bpu_top import bpu_pkg::*; #(
    parameter int BIMODAL_ENTRIES = 512,
    parameter int TAGE_ENTRIES    = 256,
    parameter int BTB_ENTRIES     = 256,
    parameter int RAS_DEPTH       = 64
) (
    input  wire logic      clk,
    input  wire logic      rst,
    // fetch side
    input  wire addr_t     if_pc_i,
    input  wire inst_t     if_inst_i,
    // execute feedback
    input  wire logic      ex_valid_i,
    input  wire logic      ex_taken_i,
    input  wire logic      ex_correct_i,
    input  wire logic      ex_ret_i,
    input  wire addr_t     ex_pc_i,
    input  wire addr_t     ex_target_i,
    input  wire ghist_t    ex_history_i,
    input  wire provider_e ex_provider_i,
    // decode call push
    input  wire logic      id_push_i,
    input  wire addr_t     id_push_addr_i,
    // prediction
    output logic           branch_o,
    output logic           taken_o,
    output addr_t          target_o,
    output provider_e      provider_o,
    output ghist_t         history_o
);

    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    logic      is_ret;
    addr_t     branch_target;
    addr_t     jal_target;
    logic      pred_taken;
    provider_e pred_provider;
    addr_t     ras_top;
    logic      ras_valid;

    inst_predecode u_predecode (
        .if_pc_i         (if_pc_i),
        .if_inst_i       (if_inst_i),
        .is_branch_o     (is_branch),
        .is_jal_o        (is_jal),
        .is_jalr_o       (is_jalr),
        .is_ret_o        (is_ret),
        .branch_target_o (branch_target),
        .jal_target_o    (jal_target)
    );

    direction_predictor #(
        .BIMODAL_ENTRIES (BIMODAL_ENTRIES),
        .TAGE_ENTRIES    (TAGE_ENTRIES)
    ) u_direction (
        .clk           (clk),
        .rst           (rst),
        .if_pc_i       (if_pc_i),
        .pred_taken_o  (pred_taken),
        .provider_o    (pred_provider),
        .ex_valid_i    (ex_valid_i),
        .ex_taken_i    (ex_taken_i),
        .ex_correct_i  (ex_correct_i),
        .ex_pc_i       (ex_pc_i),
        .ex_history_i  (ex_history_i),
        .ex_provider_i (ex_provider_i),
        .history_o     (history_o)
    );

    return_stack #(
        .RAS_DEPTH (RAS_DEPTH)
    ) u_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (id_push_i),
        .push_addr_i (id_push_addr_i),
        .pop_i       (ex_ret_i),
        .top_o       (ras_top),
        .valid_o     (ras_valid)
    );

    target_select #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_target (
        .clk             (clk),
        .rst             (rst),
        .if_pc_i         (if_pc_i),
        .is_branch_i     (is_branch),
        .is_jal_i        (is_jal),
        .is_jalr_i       (is_jalr),
        .is_ret_i        (is_ret),
        .branch_target_i (branch_target),
        .jal_target_i    (jal_target),
        .pred_taken_i    (pred_taken),
        .pred_provider_i (pred_provider),
        .ras_top_i       (ras_top),
        .ras_valid_i     (ras_valid),
        .ex_valid_i      (ex_valid_i),
        .ex_taken_i      (ex_taken_i),
        .ex_pc_i         (ex_pc_i),
        .ex_target_i     (ex_target_i),
        .branch_o        (branch_o),
        .taken_o         (taken_o),
        .target_o        (target_o),
        .provider_o      (provider_o)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;  // release on an edge, away from the sampling point
    end

endmodule

`default_nettype wire

// ==== testbench/bpu_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module bpu_properties import bpu_pkg::*; (
    input wire logic   clk,
    input wire logic   rst,
    input wire addr_t  if_pc_i,
    input wire logic   branch_i,
    input wire logic   taken_i,
    input wire addr_t  target_i,
    input wire ghist_t history_i
);

    int unsigned assert_errors = 0;  // read by the testbench summary

    // a taken prediction only for control transfers
    a_taken_is_branch: assert property (@(posedge clk) disable iff (rst)
        taken_i |-> branch_i)
    else begin
        assert_errors++;
        $error("taken_o high for an instruction that is not a control transfer");
    end

    // fall through address
    a_not_taken_next_pc: assert property (@(posedge clk) disable iff (rst)
        !taken_i |-> (target_i == if_pc_i + 32'd4))
    else begin
        assert_errors++;
        $error("target_o is not pc + 4 while taken_o is low");
    end

    a_history_reset: assert property (@(posedge clk) rst |-> (history_i == '0))
    else begin
        assert_errors++;
        $error("history_o not zero during reset");
    end

endmodule

`default_nettype wire

// ==== testbench/tb_bpu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_bpu import bpu_pkg::*; ();

    localparam int    CLK_PERIOD  = 100;
    localparam int    TEST_CYCLES = 220;  // about the length of all directed tests
    localparam inst_t NOP         = 32'h0000_0013;

    logic      clk;
    logic      rst;
    addr_t     if_pc;
    inst_t     if_inst;
    logic      ex_valid;
    logic      ex_taken;
    logic      ex_correct;
    logic      ex_ret;
    addr_t     ex_pc;
    addr_t     ex_target;
    ghist_t    ex_history;
    provider_e ex_provider;
    logic      id_push;
    addr_t     id_push_addr;
    logic      branch_o;
    logic      taken_o;
    addr_t     target_o;
    provider_e provider_o;
    ghist_t    history_o;

    ghist_t      exp_history;  // shadow of the global history since reset
    int          checks;
    int          err_flag;
    int          err_addr;
    int          err_history;
    int          err_provider;
    int          total_errors;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(4)) u_clk (.clk_o(clk), .rst_o(rst));

    bpu_top u_dut (
        .clk(clk), .rst(rst), .if_pc_i(if_pc), .if_inst_i(if_inst),
        .ex_valid_i(ex_valid), .ex_taken_i(ex_taken), .ex_correct_i(ex_correct),
        .ex_ret_i(ex_ret), .ex_pc_i(ex_pc), .ex_target_i(ex_target),
        .ex_history_i(ex_history), .ex_provider_i(ex_provider),
        .id_push_i(id_push), .id_push_addr_i(id_push_addr),
        .branch_o(branch_o), .taken_o(taken_o), .target_o(target_o),
        .provider_o(provider_o), .history_o(history_o)
    );

    bind bpu_top bpu_properties u_props (
        .clk(clk), .rst(rst), .if_pc_i(if_pc_i), .branch_i(branch_o),
        .taken_i(taken_o), .target_i(target_o), .history_i(history_o)
    );

    // instruction encoders
    function automatic inst_t branch_inst(logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd11, 5'd10, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic inst_t jal_inst(logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
    endfunction

    function automatic inst_t ret_inst(logic [4:0] link);
        return {12'd0, link, 3'b000, 5'd0, OPC_JALR};
    endfunction

    function automatic addr_t random_pc(logic [9:0] low);
        return ($urandom() & 32'hffff_fc00) | {22'd0, low};  // low bits keep tests apart
    endfunction

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            err_flag++;
            $display("error at %0t: %s is %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            err_addr++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_history(input string what, input ghist_t got, input ghist_t exp);
        checks++;
        if (got !== exp) begin
            err_history++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_provider(input string what, input provider_e got,
                                  input provider_e exp);
        checks++;
        if (got !== exp) begin
            err_provider++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_prediction(input string what, input logic branch,
                                      input logic taken, input addr_t target);
        check_flag({what, " branch_o"}, branch_o, branch);
        check_flag({what, " taken_o"}, taken_o, taken);
        check_addr({what, " target_o"}, target_o, target);
    endtask

    task automatic fetch(input addr_t pc, input inst_t inst);
        @(posedge clk);
        if_pc   <= pc;
        if_inst <= inst;
        @(negedge clk);  // prediction settled mid cycle
    endtask

    task automatic send_update(input addr_t pc, input logic taken, input logic correct,
                               input addr_t target, input ghist_t hist, input provider_e prov);
        @(posedge clk);
        ex_valid    <= 1'b1;
        ex_taken    <= taken;
        ex_correct  <= correct;
        ex_pc       <= pc;
        ex_target   <= target;
        ex_history  <= hist;
        ex_provider <= prov;
        @(posedge clk);
        ex_valid    <= 1'b0;
        exp_history = {exp_history[GHIST_W-2:0], taken};
    endtask

    task automatic stack_op(input logic push, input logic pop, input addr_t addr);
        @(posedge clk);
        id_push      <= push;
        id_push_addr <= addr;
        ex_ret       <= pop;
        @(posedge clk);
        id_push <= 1'b0;
        ex_ret  <= 1'b0;
    endtask

    task automatic non_control_insts();
        addr_t       pc;
        logic [12:0] b_imm;
        inst_t       ops [4];
        pc     = random_pc(10'h104);
        b_imm  = 13'($urandom()) & 13'h1ffe;
        ops[0] = NOP;
        ops[1] = 32'h00b5_0533;                  // add x10, x10, x11
        ops[2] = 32'h0081_2283;                  // lw x5, 8(x2)
        ops[3] = {$urandom() & 32'hffff_ff80} | 32'h37;  // lui with random fields
        check_history("history_o after reset", history_o, '0);
        for (int i = 0; i < 4; i++) begin
            fetch(pc + 32'(4 * i), ops[i]);
            compare_prediction("non-control", 1'b0, 1'b0, pc + 32'(4 * i) + 32'd4);
        end
        fetch(pc, branch_inst(b_imm));
        compare_prediction("cold branch", 1'b1, 1'b0, pc + 32'd4);
        check_provider("cold branch provider_o", provider_o, PROV_BIMODAL);
    endtask

    task automatic jal_targets();
        addr_t       pc;
        addr_t       jump;
        addr_t       learned;
        logic [20:0] j_imm;
        pc      = random_pc(10'h208);
        j_imm   = 21'($urandom()) & 21'h1ffffe;
        jump    = pc + {{11{j_imm[20]}}, j_imm};
        learned = jump + 32'h100;
        fetch(pc, jal_inst(j_imm));
        compare_prediction("jal before training", 1'b1, 1'b1, jump);
        send_update(pc, 1'b1, 1'b1, learned, history_o, PROV_BIMODAL);
        fetch(pc, jal_inst(j_imm));
        compare_prediction("jal after btb write", 1'b1, 1'b1, learned);
    endtask

    task automatic direction_training();
        addr_t       pc;
        addr_t       dest;
        logic [12:0] b_imm;
        pc    = random_pc(10'h30c);
        b_imm = 13'($urandom()) & 13'h1ffe;
        dest  = pc + {{19{b_imm[12]}}, b_imm};
        repeat (20) begin
            fetch(pc, branch_inst(b_imm));
            send_update(pc, 1'b1, taken_o == 1'b1, dest, history_o, provider_o);
        end
        fetch(pc, branch_inst(b_imm));
        compare_prediction("branch trained taken", 1'b1, 1'b1, dest);
        repeat (20) begin
            fetch(pc, branch_inst(b_imm));
            send_update(pc, 1'b0, taken_o == 1'b0, dest, history_o, provider_o);
        end
        fetch(pc, branch_inst(b_imm));
        compare_prediction("branch trained not taken", 1'b1, 1'b0, pc + 32'd4);
    endtask

    task automatic history_shift();
        addr_t pc;
        logic  outcome;
        pc = random_pc(10'h010);
        check_history("history_o before pattern", history_o, exp_history);
        repeat (20) begin
            outcome = 1'($urandom());
            send_update(pc, outcome, 1'b1, pc + 32'h20, history_o, PROV_BIMODAL);
            @(negedge clk);
            check_history("history_o", history_o, exp_history);
        end
    endtask

    task automatic stack_returns();
        addr_t pc;
        addr_t call_a;
        addr_t call_b;
        addr_t call_c;
        pc     = random_pc(10'h0a0);
        call_a = $urandom() & 32'hffff_fffc;
        call_b = $urandom() & 32'hffff_fffc;
        call_c = $urandom() & 32'hffff_fffc;
        stack_op(1'b1, 1'b0, call_a);
        stack_op(1'b1, 1'b0, call_b);
        fetch(pc, ret_inst(REG_RA));
        compare_prediction("ret after two pushes", 1'b1, 1'b1, call_b);
        stack_op(1'b0, 1'b1, '0);
        fetch(pc, ret_inst(REG_T0));  // t0 link register
        compare_prediction("ret after one pop", 1'b1, 1'b1, call_a);
        stack_op(1'b0, 1'b1, '0);
        fetch(pc, ret_inst(REG_RA));
        compare_prediction("ret on empty stack", 1'b1, 1'b0, pc + 32'd4);
        stack_op(1'b1, 1'b0, call_a);
        stack_op(1'b1, 1'b0, call_b);
        stack_op(1'b1, 1'b1, call_c);  // pop then push keeps depth at two
        fetch(pc, ret_inst(REG_RA));
        compare_prediction("ret after push with pop", 1'b1, 1'b1, call_c);
        stack_op(1'b0, 1'b1, '0);
        fetch(pc, ret_inst(REG_RA));
        compare_prediction("ret below replaced top", 1'b1, 1'b1, call_a);
        stack_op(1'b0, 1'b1, '0);
        fetch(pc, ret_inst(REG_RA));
        compare_prediction("ret on drained stack", 1'b1, 1'b0, pc + 32'd4);
    endtask

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog expired: the tests did not finish within %0d cycles",
                 2 * TEST_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(54));
        if_pc        = '0;
        if_inst      = NOP;
        ex_valid     = 1'b0;
        ex_taken     = 1'b0;
        ex_correct   = 1'b0;
        ex_ret       = 1'b0;
        ex_pc        = '0;
        ex_target    = '0;
        ex_history   = '0;
        ex_provider  = PROV_BIMODAL;
        id_push      = 1'b0;
        id_push_addr = '0;
        exp_history  = '0;
        checks       = 0;
        err_flag     = 0;
        err_addr     = 0;
        err_history  = 0;
        err_provider = 0;
        wait (rst == 1'b0);
        @(negedge clk);
        non_control_insts();
        jal_targets();
        direction_training();  // history is 0001 after the jal update
        history_shift();
        stack_returns();
        total_errors = err_flag + err_addr + err_history + err_provider
                     + int'(u_dut.u_props.assert_errors);
        $display("%0d checks, errors: flag %0d, addr %0d, history %0d, provider %0d, assert %0d",
                 checks, err_flag, err_addr, err_history, err_provider,
                 u_dut.u_props.assert_errors);
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/bpu_pkg.sv
verilog/tagged_table.sv
verilog/inst_predecode.sv
verilog/direction_predictor.sv
verilog/return_stack.sv
verilog/target_select.sv
verilog/bpu_top.sv
testbench/tb_clock_gen.sv
testbench/bpu_properties.sv
testbench/tb_bpu.sv
